//--- Bender.yml
package:
  name: cache

sources:
  - rtl/cache_pkg.sv
  - rtl/line_array.sv
  - rtl/plru_tree.sv
  - rtl/cache_datapath.sv
  - rtl/cache_control.sv
  - rtl/cache_top.sv
  - target: test
    files:
      - testbench/tb_clock.sv
      - testbench/pmem_model.sv
      - testbench/tb_cache.sv

//--- rtl/cache_control.sv
`timescale 1ns/1ns

module cache_control (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      mem_read,
    input  logic                      mem_write,
    input  logic                      pmem_resp,
    input  logic                      hit,
    input  logic                      victim_dirty,
    output logic                      mem_resp,
    output logic                      pmem_read,
    output logic                      pmem_write,
    output logic                      ld_valid,
    output logic                      ld_dirty,
    output logic                      ld_tag,
    output logic                      ld_data,
    output logic                      ld_plru,
    output logic                      dirty_val,
    output cache_pkg::way_sel_e       dirty_way_sel,
    output cache_pkg::way_sel_e       data_way_sel,
    output cache_pkg::data_src_e      data_src,
    output cache_pkg::pmem_addr_sel_e pmem_addr_sel
);
    import cache_pkg::*;

    cache_state_e state_q;
    cache_state_e state_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= idle;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d       = state_q;
        mem_resp      = 1'b0;
        pmem_read     = 1'b0;
        pmem_write    = 1'b0;
        ld_valid      = 1'b0;
        ld_dirty      = 1'b0;
        ld_tag        = 1'b0;
        ld_data       = 1'b0;
        ld_plru       = 1'b0;
        dirty_val     = 1'b0;
        dirty_way_sel = sel_hit_way;
        data_way_sel  = sel_hit_way;
        data_src      = src_cpu;
        pmem_addr_sel = addr_req;

        case (state_q)
            idle: begin
                // the arrays are read at this edge, check sees the stored set.
                if (mem_read || mem_write) begin
                    state_d = check;
                end
            end
            check: begin
                if (hit) begin
                    mem_resp = 1'b1;
                    ld_plru  = 1'b1;
                    if (mem_write) begin
                        ld_data   = 1'b1;  // masked merge into the hit way.
                        ld_dirty  = 1'b1;
                        dirty_val = 1'b1;
                    end
                    state_d = idle;
                end else if (victim_dirty) begin
                    state_d = write_back;
                end else begin
                    state_d = refill;
                end
            end
            write_back: begin
                pmem_write    = 1'b1;
                pmem_addr_sel = addr_victim;  // the old line goes back to its own address.
                if (pmem_resp) begin
                    state_d = refill;
                end
            end
            refill: begin
                pmem_read = 1'b1;
                if (pmem_resp) begin
                    // The new line lands in the victim way, clean and valid.
                    // idle then replays the request, which now hits.
                    ld_data       = 1'b1;
                    ld_tag        = 1'b1;
                    ld_valid      = 1'b1;
                    ld_dirty      = 1'b1;
                    data_src      = src_mem;
                    data_way_sel  = sel_victim_way;
                    dirty_way_sel = sel_victim_way;
                    state_d       = idle;
                end
            end
            default: begin
                state_d = idle;
            end
        endcase
    end

    // a memory strobe stays up until the memory answers it.
    a_pmem_held: assert property (@(posedge clk) disable iff (rst)
        (pmem_read || pmem_write) && !pmem_resp |=> $stable({pmem_read, pmem_write}));

    // a written-back victim is always followed by the refill of its set.
    a_refill_after_wb: assert property (@(posedge clk) disable iff (rst)
        pmem_write && pmem_resp |=> pmem_read && !pmem_write);

endmodule

//--- rtl/cache_datapath.sv
`timescale 1ns/1ns

module cache_datapath (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [31:0]                    mem_address,
    input  logic [cache_pkg::mask_bits-1:0] mem_byte_enable,
    input  logic [cache_pkg::word_bits-1:0] mem_wdata,
    output logic [cache_pkg::word_bits-1:0] mem_rdata,

    output logic [31:0]                    pmem_address,
    output logic [cache_pkg::word_bits-1:0] pmem_wdata,
    input  logic [cache_pkg::word_bits-1:0] pmem_rdata,

    output logic                           hit,
    output logic                           victim_dirty,

    input  logic                           ld_valid,
    input  logic                           ld_dirty,
    input  logic                           ld_tag,
    input  logic                           ld_data,
    input  logic                           ld_plru,
    input  logic                           dirty_val,
    input  cache_pkg::way_sel_e            dirty_way_sel,
    input  cache_pkg::way_sel_e            data_way_sel,
    input  cache_pkg::data_src_e           data_src,
    input  cache_pkg::pmem_addr_sel_e      pmem_addr_sel
);
    import cache_pkg::*;

    logic [tag_bits-1:0]     addr_tag;
    logic [index_bits-1:0]   addr_index;

    logic [word_bits-1:0]    data_q  [num_ways];
    logic [word_bits-1:0]    tag_raw [num_ways];  // tag arrays are line wide.
    logic [tag_bits-1:0]     tag_q   [num_ways];
    logic [num_sets-1:0]     valid_q [num_ways];
    logic [num_sets-1:0]     dirty_q [num_ways];

    logic [num_ways-1:0]     hit_vec;
    logic [way_idx_bits-1:0] hit_way;
    logic [way_idx_bits-1:0] lru_way;
    logic [way_idx_bits-1:0] victim_way;
    logic [way_idx_bits-1:0] data_way;
    logic [way_idx_bits-1:0] dirty_way;

    logic [word_bits-1:0]    data_din;
    logic [mask_bits-1:0]    data_mask;
    logic [word_bits-1:0]    tag_din;

    assign addr_tag   = mem_address[31 -: tag_bits];
    assign addr_index = mem_address[offset_bits +: index_bits];

    // Hit detection. A way only hits when it holds a valid line.
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < num_ways; w++) begin
            hit_vec[w] = valid_q[w][addr_index] && (tag_q[w] == addr_tag);
            if (hit_vec[w]) begin
                hit_way = w[way_idx_bits-1:0];
            end
        end
    end

    assign hit = |hit_vec;

    // An empty way is filled before anything is evicted.
    always_comb begin
        victim_way = lru_way;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_q[w][addr_index]) begin
                victim_way = w[way_idx_bits-1:0];
            end
        end
    end

    assign victim_dirty = valid_q[victim_way][addr_index] && dirty_q[victim_way][addr_index];

    assign data_way  = (data_way_sel == sel_victim_way) ? victim_way : hit_way;
    assign dirty_way = (dirty_way_sel == sel_victim_way) ? victim_way : hit_way;

    // A refill writes the whole line, a processor write only its enabled bytes.
    assign data_din  = (data_src == src_mem) ? pmem_rdata : mem_wdata;
    assign data_mask = (data_src == src_mem) ? {mask_bits{1'b1}} : mem_byte_enable;
    assign tag_din   = {{(word_bits - tag_bits){1'b0}}, addr_tag};

    assign mem_rdata  = data_q[hit_way];
    assign pmem_wdata = data_q[victim_way];  // only a dirty victim is sent out.

    always_comb begin
        if (pmem_addr_sel == addr_victim) begin
            pmem_address = {tag_q[victim_way], addr_index, {offset_bits{1'b0}}};
        end else begin
            pmem_address = {addr_tag, addr_index, {offset_bits{1'b0}}};
        end
    end

    for (genvar w = 0; w < num_ways; w++) begin : g_way
        line_array i_data (
            .clk   (clk),
            .we    (ld_data && (data_way == way_idx_bits'(w))),
            .wmask (data_mask),
            .addr  (addr_index),
            .din   (data_din),
            .dout  (data_q[w])
        );

        line_array i_tag (
            .clk   (clk),
            .we    (ld_tag && (victim_way == way_idx_bits'(w))),
            .wmask ({mask_bits{1'b1}}),
            .addr  (addr_index),
            .din   (tag_din),
            .dout  (tag_raw[w])
        );

        assign tag_q[w] = tag_raw[w][tag_bits-1:0];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < num_ways; w++) begin
                valid_q[w] <= '0;
                dirty_q[w] <= '0;
            end
        end else begin
            if (ld_valid) begin
                valid_q[victim_way][addr_index] <= 1'b1;  // lines are never invalidated.
            end
            if (ld_dirty) begin
                dirty_q[dirty_way][addr_index] <= dirty_val;
            end
        end
    end

    plru_tree i_plru (
        .clk       (clk),
        .rst       (rst),
        .index     (addr_index),
        .touch     (ld_plru),
        .touch_way (hit_way),
        .lru_way   (lru_way)
    );

    // when the controller accepts a hit, exactly one way must match.
    a_single_hit: assert property (@(posedge clk) disable iff (rst)
        ld_plru |-> $onehot(hit_vec));

endmodule

//--- rtl/cache_pkg.sv
package cache_pkg;

    // line geometry. One request moves a whole line.
    localparam int word_bits    = 256;
    localparam int mask_bits    = word_bits / 8;  // one enable per byte.
    localparam int offset_bits  = 5;
    localparam int index_bits   = 4;
    localparam int num_sets     = 2 ** index_bits;
    localparam int way_idx_bits = 2;
    localparam int num_ways     = 2 ** way_idx_bits;
    localparam int tag_bits     = 32 - index_bits - offset_bits;

    // controller states.
    typedef enum logic [1:0] {
        idle,
        check,        // stored tags are valid here, hit or miss is decided.
        write_back,
        refill
    } cache_state_e;

    // which way a data or dirty write goes to.
    typedef enum logic {
        sel_hit_way,
        sel_victim_way
    } way_sel_e;

    // source of the data array input.
    typedef enum logic {
        src_cpu,      // processor data under the byte mask.
        src_mem       // full line from memory.
    } data_src_e;

    // tag used to build the memory address.
    typedef enum logic {
        addr_req,
        addr_victim
    } pmem_addr_sel_e;

endpackage

//--- rtl/cache_top.sv
`timescale 1ns/1ns

module cache_top (
    input  logic                           clk,
    input  logic                           rst,

    input  logic [31:0]                    mem_address,
    input  logic                           mem_read,
    input  logic                           mem_write,
    input  logic [cache_pkg::mask_bits-1:0] mem_byte_enable,
    input  logic [cache_pkg::word_bits-1:0] mem_wdata,
    output logic [cache_pkg::word_bits-1:0] mem_rdata,
    output logic                           mem_resp,

    output logic [31:0]                    pmem_address,
    output logic                           pmem_read,
    output logic                           pmem_write,
    output logic [cache_pkg::word_bits-1:0] pmem_wdata,
    input  logic [cache_pkg::word_bits-1:0] pmem_rdata,
    input  logic                           pmem_resp
);
    import cache_pkg::*;

    logic           hit;
    logic           victim_dirty;
    logic           ld_valid;
    logic           ld_dirty;
    logic           ld_tag;
    logic           ld_data;
    logic           ld_plru;
    logic           dirty_val;
    way_sel_e       dirty_way_sel;
    way_sel_e       data_way_sel;
    data_src_e      data_src;
    pmem_addr_sel_e pmem_addr_sel;

    cache_control i_control (
        .clk           (clk),
        .rst           (rst),
        .mem_read      (mem_read),
        .mem_write     (mem_write),
        .pmem_resp     (pmem_resp),
        .hit           (hit),
        .victim_dirty  (victim_dirty),
        .mem_resp      (mem_resp),
        .pmem_read     (pmem_read),
        .pmem_write    (pmem_write),
        .ld_valid      (ld_valid),
        .ld_dirty      (ld_dirty),
        .ld_tag        (ld_tag),
        .ld_data       (ld_data),
        .ld_plru       (ld_plru),
        .dirty_val     (dirty_val),
        .dirty_way_sel (dirty_way_sel),
        .data_way_sel  (data_way_sel),
        .data_src      (data_src),
        .pmem_addr_sel (pmem_addr_sel)
    );

    cache_datapath i_datapath (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .pmem_address    (pmem_address),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .hit             (hit),
        .victim_dirty    (victim_dirty),
        .ld_valid        (ld_valid),
        .ld_dirty        (ld_dirty),
        .ld_tag          (ld_tag),
        .ld_data         (ld_data),
        .ld_plru         (ld_plru),
        .dirty_val       (dirty_val),
        .dirty_way_sel   (dirty_way_sel),
        .data_way_sel    (data_way_sel),
        .data_src        (data_src),
        .pmem_addr_sel   (pmem_addr_sel)
    );

endmodule

//--- rtl/line_array.sv
`timescale 1ns/1ns

module line_array (
    input  logic                            clk,
    input  logic                            we,
    input  logic [cache_pkg::mask_bits-1:0]  wmask,
    input  logic [cache_pkg::index_bits-1:0] addr,
    input  logic [cache_pkg::word_bits-1:0]  din,
    output logic [cache_pkg::word_bits-1:0]  dout
);
    import cache_pkg::*;

    logic [word_bits-1:0] mem [num_sets];

    // each mask bit enables one byte lane of the addressed entry.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int b = 0; b < mask_bits; b++) begin
                if (wmask[b]) begin
                    mem[addr][b*8 +: 8] <= din[b*8 +: 8];
                end
            end
        end
    end

    // The read is registered, so dout shows the entry one cycle after addr.
    // A write to the same entry in that cycle is not seen until the next read.
    always_ff @(posedge clk) begin
        dout <= mem[addr];
    end

endmodule

//--- rtl/plru_tree.sv
`timescale 1ns/1ns

module plru_tree (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [cache_pkg::index_bits-1:0]   index,
    input  logic                              touch,
    input  logic [cache_pkg::way_idx_bits-1:0] touch_way,
    output logic [cache_pkg::way_idx_bits-1:0] lru_way
);
    import cache_pkg::*;

    // Three bits per set. Bit 0 is the root and picks a half, bit 1 picks
    // between ways 0 and 1, bit 2 picks between ways 2 and 3.
    // every bit points at the side to evict next.
    logic [num_ways-2:0] tree_q [num_sets];
    logic [num_ways-2:0] cur_bits;

    assign cur_bits = tree_q[index];  // bits of the set being addressed.

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                tree_q[s] <= '0;
            end
        end else if (touch) begin
            // root turns to the half that was not used.
            tree_q[index][0] <= ~touch_way[1];
            // the leaf of the used half turns to its other way.
            tree_q[index][1 + touch_way[1]] <= ~touch_way[0];
        end
    end

    // follow the root, then the leaf of the chosen half.
    always_comb begin
        lru_way[1] = cur_bits[0];
        if (cur_bits[0]) begin
            lru_way[0] = cur_bits[2];
        end else begin
            lru_way[0] = cur_bits[1];
        end
    end

endmodule

//--- tb.f
rtl/cache_pkg.sv
rtl/line_array.sv
rtl/plru_tree.sv
rtl/cache_datapath.sv
rtl/cache_control.sv
rtl/cache_top.sv
testbench/tb_clock.sv
testbench/pmem_model.sv
testbench/tb_cache.sv

//--- testbench/pmem_model.sv
`timescale 1ns/1ns

module pmem_model (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [31:0]                     pmem_address,
    input  logic                            pmem_read,
    input  logic                            pmem_write,
    input  logic [cache_pkg::word_bits-1:0] pmem_wdata,
    output logic [cache_pkg::word_bits-1:0] pmem_rdata,
    output logic                            pmem_resp
);
    import cache_pkg::*;

    logic [31:0]          line_addr [$];  // lines that have been written back.
    logic [word_bits-1:0] line_data [$];
    logic [31:0]          write_addr_log [$];
    logic [word_bits-1:0] write_data_log [$];
    logic [31:0]          last_read_addr;
    int                   read_count;
    int                   write_count;
    int                   busy_cycles;

    // An untouched line holds a pattern that mixes in every address bit.
    function automatic logic [word_bits-1:0] preset_line(input logic [31:0] addr);
        logic [word_bits-1:0] line;
        for (int k = 0; k < word_bits / 32; k++) begin
            line[k*32 +: 32] = (addr ^ (32'(k) * 32'h0101_0101)) * 32'h9e37_79b1;
        end
        return line;
    endfunction

    function automatic logic [word_bits-1:0] line_at(input logic [31:0] addr);
        for (int i = 0; i < line_addr.size(); i++) begin
            if (line_addr[i] == addr) begin
                return line_data[i];
            end
        end
        return preset_line(addr);
    endfunction

    task automatic store_line(input logic [31:0] addr, input logic [word_bits-1:0] data);
        for (int i = 0; i < line_addr.size(); i++) begin
            if (line_addr[i] == addr) begin
                line_data[i] = data;
                return;
            end
        end
        line_addr.push_back(addr);
        line_data.push_back(data);
    endtask

    initial begin
        pmem_resp      = 1'b0;
        pmem_rdata     = '0;
        last_read_addr = '0;
        read_count     = 0;
        write_count    = 0;
        busy_cycles    = 0;
    end

    // The memory answers on falling edges, so the cache sees a settled pulse.
    always @(negedge clk) begin
        if (rst || pmem_resp) begin
            pmem_resp <= 1'b0;  // the pulse lasts one cycle.
            busy_cycles = 0;
        end else if (pmem_read || pmem_write) begin
            busy_cycles++;
            if (busy_cycles == 3) begin
                if (pmem_read) begin
                    pmem_rdata <= line_at(pmem_address);
                    last_read_addr = pmem_address;
                    read_count++;
                end else begin
                    store_line(pmem_address, pmem_wdata);
                    write_addr_log.push_back(pmem_address);
                    write_data_log.push_back(pmem_wdata);
                    write_count++;
                end
                pmem_resp <= 1'b1;
            end
        end
    end

endmodule

//--- testbench/tb_cache.sv
`timescale 1ns/1ns

module tb_cache;
    import cache_pkg::*;

    logic                 clk;
    logic                 rst;
    logic [31:0]          mem_address;
    logic                 mem_read;
    logic                 mem_write;
    logic [mask_bits-1:0] mem_byte_enable;
    logic [word_bits-1:0] mem_wdata;
    logic [word_bits-1:0] mem_rdata;
    logic                 mem_resp;
    logic [31:0]          pmem_address;
    logic                 pmem_read;
    logic                 pmem_write;
    logic [word_bits-1:0] pmem_wdata;
    logic [word_bits-1:0] pmem_rdata;
    logic                 pmem_resp;

    logic [31:0]          lfsr_q;
    logic [31:0]          shadow_addr [$];  // expected content of every line touched.
    logic [word_bits-1:0] shadow_data [$];
    int                   error_count;
    int                   check_count;
    int                   failed_tests;
    int                   write_seen;  // memory writes already compared.

    tb_clock i_clock (
        .clk (clk),
        .rst (rst)
    );

    cache_top i_dut (
        .clk             (clk),
        .rst             (rst),
        .mem_address     (mem_address),
        .mem_read        (mem_read),
        .mem_write       (mem_write),
        .mem_byte_enable (mem_byte_enable),
        .mem_wdata       (mem_wdata),
        .mem_rdata       (mem_rdata),
        .mem_resp        (mem_resp),
        .pmem_address    (pmem_address),
        .pmem_read       (pmem_read),
        .pmem_write      (pmem_write),
        .pmem_wdata      (pmem_wdata),
        .pmem_rdata      (pmem_rdata),
        .pmem_resp       (pmem_resp)
    );

    pmem_model i_mem (
        .clk          (clk),
        .rst          (rst),
        .pmem_address (pmem_address),
        .pmem_read    (pmem_read),
        .pmem_write   (pmem_write),
        .pmem_wdata   (pmem_wdata),
        .pmem_rdata   (pmem_rdata),
        .pmem_resp    (pmem_resp)
    );

    // x^32 + x^22 + x^2 + x + 1 in Galois form.
    function automatic logic [31:0] galois_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    function automatic logic [word_bits-1:0] random_bits(input int n);
        logic [word_bits-1:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = galois_step(lfsr_q);  // one step for every bit taken.
        end
        return v;
    endfunction

    function automatic logic [31:0] make_addr(input logic [tag_bits-1:0] tag,
                                              input logic [index_bits-1:0] index);
        return {tag, index, {offset_bits{1'b0}}};
    endfunction

    function automatic logic [31:0] line_of(input logic [31:0] addr);
        return {addr[31:offset_bits], {offset_bits{1'b0}}};
    endfunction

    function automatic logic [word_bits-1:0] merge_bytes(input logic [word_bits-1:0] old_line,
                                                         input logic [word_bits-1:0] data,
                                                         input logic [mask_bits-1:0] mask);
        logic [word_bits-1:0] line;
        line = old_line;
        for (int b = 0; b < mask_bits; b++) begin
            if (mask[b]) begin
                line[b*8 +: 8] = data[b*8 +: 8];
            end
        end
        return line;
    endfunction

    function automatic logic [word_bits-1:0] shadow_line(input logic [31:0] addr);
        for (int i = 0; i < shadow_addr.size(); i++) begin
            if (shadow_addr[i] == addr) begin
                return shadow_data[i];
            end
        end
        return i_mem.preset_line(addr);  // never written, so memory still holds its preset.
    endfunction

    task automatic shadow_store(input logic [31:0] addr, input logic [word_bits-1:0] data);
        for (int i = 0; i < shadow_addr.size(); i++) begin
            if (shadow_addr[i] == addr) begin
                shadow_data[i] = data;
                return;
            end
        end
        shadow_addr.push_back(addr);
        shadow_data.push_back(data);
    endtask

    task automatic check_value(input string test, input string what,
                               input logic [word_bits-1:0] expected,
                               input logic [word_bits-1:0] actual);
        check_count++;
        assert (actual === expected) else begin
            $display("** Error %s: %s expected %0h, actual %0h", test, what, expected, actual);
            error_count++;
        end
    endtask

    // Called on a falling edge. Returns on the falling edge after the response.
    task automatic access(input string test, input logic is_write, input logic [31:0] addr,
                          input logic [mask_bits-1:0] mask, input logic [word_bits-1:0] data,
                          output logic [word_bits-1:0] rdata, output int waited);
        bit done;
        done            = 1'b0;
        waited          = 0;
        rdata           = '0;
        mem_address     = addr;
        mem_read        = !is_write;
        mem_write       = is_write;
        mem_byte_enable = mask;
        mem_wdata       = data;
        while (!done && waited < 50) begin
            @(negedge clk);
            waited++;
            if (mem_resp) begin
                done  = 1'b1;
                rdata = mem_rdata;
            end
        end
        if (done) begin
            @(negedge clk);  // the rising edge in between takes the response.
        end else begin
            $display("%s: the cache gave no response within 50 cycles", test);
            error_count++;
        end
        mem_read  = 1'b0;
        mem_write = 1'b0;
    endtask

    // every new write-back must carry what the shadow holds for its line.
    task automatic check_new_writes(input string test);
        for (int i = write_seen; i < i_mem.write_count; i++) begin
            check_value(test, "write-back data", shadow_line(i_mem.write_addr_log[i]),
                        i_mem.write_data_log[i]);
        end
        write_seen = i_mem.write_count;
    endtask

    task automatic report_test(input string test, input int errors_before);
        if (error_count == errors_before) begin
            $display("%s: ok", test);
        end else begin
            failed_tests++;
            $display("%s: FAILED with %0d errors", test, error_count - errors_before);
        end
    endtask

    task automatic read_miss_refill();
        logic [31:0]          addr;
        logic [word_bits-1:0] rdata;
        int                   waited;
        int                   reads_before;
        int                   writes_before;
        int                   errors_before;
        errors_before = error_count;
        addr          = {23'h01234, 4'h3, 5'h0c};  // offset bits set, memory sees them clear.
        reads_before  = i_mem.read_count;
        writes_before = i_mem.write_count;
        access("read_miss_refill", 1'b0, addr, '0, '0, rdata, waited);
        check_value("read_miss_refill", "read data", shadow_line(line_of(addr)), rdata);
        check_value("read_miss_refill", "memory reads", 1, i_mem.read_count - reads_before);
        check_value("read_miss_refill", "read address", line_of(addr), i_mem.last_read_addr);
        check_value("read_miss_refill", "memory writes", 0, i_mem.write_count - writes_before);
        report_test("read_miss_refill", errors_before);
    endtask

    task automatic read_hit();
        logic [31:0]          addr;
        logic [word_bits-1:0] rdata;
        int                   waited;
        int                   reads_before;
        int                   writes_before;
        int                   errors_before;
        errors_before = error_count;
        addr          = {23'h01234, 4'h3, 5'h0c};
        reads_before  = i_mem.read_count;
        writes_before = i_mem.write_count;
        access("read_hit", 1'b0, addr, '0, '0, rdata, waited);
        check_value("read_hit", "read data", shadow_line(line_of(addr)), rdata);
        check_value("read_hit", "memory reads", 0, i_mem.read_count - reads_before);
        check_value("read_hit", "memory writes", 0, i_mem.write_count - writes_before);
        // Edges from the one that sees the request to the one that takes mem_resp.
        check_value("read_hit", "latency", 2, waited + 1);
        report_test("read_hit", errors_before);
    endtask

    task automatic write_hit_masked();
        logic [31:0]          addr;
        logic [mask_bits-1:0] mask;
        logic [word_bits-1:0] data;
        logic [word_bits-1:0] expected;
        logic [word_bits-1:0] rdata;
        int                   waited;
        int                   reads_before;
        int                   writes_before;
        int                   errors_before;
        errors_before = error_count;
        addr          = make_addr(23'h01234, 4'h3);
        mask          = mask_bits'(random_bits(mask_bits));
        data          = random_bits(word_bits);
        expected      = merge_bytes(shadow_line(addr), data, mask);
        reads_before  = i_mem.read_count;
        writes_before = i_mem.write_count;
        access("write_hit_masked", 1'b1, addr, mask, data, rdata, waited);
        shadow_store(addr, expected);
        access("write_hit_masked", 1'b0, addr, '0, '0, rdata, waited);
        check_value("write_hit_masked", "read data", expected, rdata);
        check_value("write_hit_masked", "memory reads", 0, i_mem.read_count - reads_before);
        check_value("write_hit_masked", "memory writes", 0, i_mem.write_count - writes_before);
        report_test("write_hit_masked", errors_before);
    endtask

    task automatic victim_write_back();
        logic [31:0]          first;
        logic [31:0]          addr;
        logic [mask_bits-1:0] mask;
        logic [word_bits-1:0] data;
        logic [word_bits-1:0] rdata;
        int                   waited;
        int                   reads_before;
        int                   writes_before;
        int                   errors_before;
        errors_before = error_count;
        first         = make_addr(23'h200, 4'h9);
        mask          = mask_bits'(random_bits(mask_bits));
        data          = random_bits(word_bits);
        access("victim_write_back", 1'b1, first, mask, data, rdata, waited);
        shadow_store(first, merge_bytes(shadow_line(first), data, mask));
        for (int k = 1; k < num_ways; k++) begin
            addr = make_addr(tag_bits'(32'h200 + k), 4'h9);
            access("victim_write_back", 1'b0, addr, '0, '0, rdata, waited);
            check_value("victim_write_back", "fill read data", shadow_line(addr), rdata);
        end
        // ways were used 0 to 3 in order, so the tree now points at way 0.
        addr          = make_addr(23'h204, 4'h9);
        reads_before  = i_mem.read_count;
        writes_before = i_mem.write_count;
        access("victim_write_back", 1'b0, addr, '0, '0, rdata, waited);
        check_value("victim_write_back", "memory writes", 1, i_mem.write_count - writes_before);
        if (i_mem.write_count > 0) begin
            check_value("victim_write_back", "write-back address", first,
                        i_mem.write_addr_log[i_mem.write_count - 1]);
        end
        check_new_writes("victim_write_back");
        check_value("victim_write_back", "read data", shadow_line(addr), rdata);
        check_value("victim_write_back", "memory reads", 1, i_mem.read_count - reads_before);
        report_test("victim_write_back", errors_before);
    endtask

    task automatic random_mix();
        logic [index_bits-1:0] index;
        logic [tag_bits-1:0]   tag;
        logic                  is_write;
        logic [31:0]           addr;
        logic [mask_bits-1:0]  mask;
        logic [word_bits-1:0]  data;
        logic [word_bits-1:0]  expected;
        logic [word_bits-1:0]  rdata;
        int                    waited;
        int                    errors_before;
        errors_before = error_count;
        for (int op = 0; op < 40; op++) begin
            index    = index_bits'(5 + random_bits(2) % 3);  // sets 5, 6 and 7.
            tag      = tag_bits'(32'h300 + random_bits(3) % 6);
            is_write = (random_bits(1) != 0);
            addr     = make_addr(tag, index);
            mask     = '0;
            data     = '0;
            if (is_write) begin
                mask = mask_bits'(random_bits(mask_bits));
                data = random_bits(word_bits);
            end
            expected = merge_bytes(shadow_line(addr), data, mask);
            access("random_mix", is_write, addr, mask, data, rdata, waited);
            check_new_writes("random_mix");  // the victim is never the requested line.
            if (is_write) begin
                shadow_store(addr, expected);
            end else begin
                check_value("random_mix", "read data", expected, rdata);
            end
        end
        report_test("random_mix", errors_before);
    endtask

    initial begin
        int n;
        mem_address     = '0;
        mem_read        = 1'b0;
        mem_write       = 1'b0;
        mem_byte_enable = '0;
        mem_wdata       = '0;
        lfsr_q          = 32'd95;
        error_count     = 0;
        check_count     = 0;
        failed_tests    = 0;
        write_seen      = 0;
        n               = 0;

        while (rst !== 1'b0 && n < 20) begin
            @(posedge clk);
            n++;
        end
        if (rst !== 1'b0) begin
            $display("reset was still active after 20 cycles");
            error_count++;
        end
        @(negedge clk);

        read_miss_refill();
        read_hit();
        write_hit_masked();
        victim_write_back();
        random_mix();

        $display("tests run: 5, tests failed: %0d, checks: %0d, errors: %0d",
                 failed_tests, check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period.
    end

    // reset covers four rising edges and is released on a falling edge.
    initial begin
        rst = 1'b1;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule
